//--- rtl/mem_pipe_pkg.sv
package mem_pipe_pkg;

    // access size as encoded by the decoder
    typedef enum logic [1:0] {
        width_byte = 2'd0,
        width_half = 2'd1,
        width_word = 2'd2   // 2'd3 unused
    } mem_width_e;

    // loongarch style ecode values
    typedef enum logic [6:0] {
        exc_none = 7'h00,
        exc_adem = 7'h08,   // address outside memory
        exc_ale  = 7'h09    // misaligned half or word
    } mem_exc_e;

    // what execute hands to the memory stage
    typedef struct packed {
        logic       en;
        logic       write;    // 1 store, 0 load
        logic       sign;     // sign extend loads
        mem_width_e width;
        logic [4:0] rd;
        logic [31:0] base;    // source register value
        logic [31:0] imm;
        logic [31:0] data;    // store data, low bytes used for byte/half
        mem_exc_e   exc;      // fault from earlier stages
    } mem_in_t;

    // stage register between issue and response halves
    typedef struct packed {
        logic       en;
        logic       write;
        logic       sign;
        mem_width_e width;
        logic [4:0] rd;
        logic [1:0] addr_low;   // byte position inside the word
        mem_exc_e   exc;
    } mem_pass_t;

    // stage result toward writeback
    typedef struct packed {
        logic       en;
        logic [4:0] rd;
        logic [31:0] data;
        mem_exc_e   exc;
        logic [31:0] badv;   // faulting address for adem
    } mem_out_t;

endpackage

//--- rtl/cache_port_pkg.sv
package cache_port_pkg;

    // direction of a cache access
    typedef enum logic {
        cache_read  = 1'b0,
        cache_write = 1'b1
    } cache_op_e;

    // request level toward the cache
    // valid is a plain enable, taken at the edge where it is high
    typedef struct packed {
        logic        valid;
        cache_op_e   op;
        logic [31:0] addr;    // byte address, used as physical
        logic [3:0]  wstrb;   // byte lane enables
        logic [31:0] wdata;   // store data already placed on its lanes
    } cache_req_t;

    // answer from the cache
    // one data_valid pulse per accepted request
    typedef struct packed {
        logic                  data_valid;
        logic [31:0]           rdata;   // whole aligned word
        mem_pipe_pkg::mem_exc_e exc;    // adem only
        logic [31:0]           badv;
    } cache_rsp_t;

endpackage

//--- rtl/mem_issue.sv
`timescale 1ns/1ns

module mem_issue (
    input  logic                       clk,
    input  logic                       reset,
    input  mem_pipe_pkg::mem_in_t      mem_in,     // from execute
    input  logic                       stall,      // hold from the response half
    output cache_port_pkg::cache_req_t cache_req,
    output mem_pipe_pkg::mem_pass_t    pass        // in-flight access info
);

    logic [31:0] addr;
    logic        misalign;
    logic        exc_in;       // upstream already faulted
    logic [3:0]  strb_base;    // strobes before shifting to the address
    logic [31:0] lane_data;    // store data copied across lanes

    mem_pipe_pkg::mem_pass_t pass_d;
    mem_pipe_pkg::mem_pass_t pass_q;

    assign addr   = mem_in.base + mem_in.imm;   // base register plus offset
    assign exc_in = (mem_in.exc != mem_pipe_pkg::exc_none);

    // half needs even address, word needs multiple of four
    always_comb begin
        case (mem_in.width)
            mem_pipe_pkg::width_half: misalign = addr[0];
            mem_pipe_pkg::width_word: misalign = |addr[1:0];
            default:                  misalign = 1'b0;   // bytes always fit
        endcase
    end

    // lane strobes and replicated store data
    always_comb begin
        case (mem_in.width)
            mem_pipe_pkg::width_byte: begin
                strb_base = 4'b0001;
                lane_data = {4{mem_in.data[7:0]}};
            end
            mem_pipe_pkg::width_half: begin
                strb_base = 4'b0011;
                lane_data = {2{mem_in.data[15:0]}};
            end
            default: begin
                strb_base = 4'b1111;   // word, also the spare encoding
                lane_data = mem_in.data;
            end
        endcase
    end

    // request goes straight from the stage inputs
    always_comb begin
        // faulted or held accesses never reach the cache
        cache_req.valid = mem_in.en && !misalign && !exc_in && !stall;
        cache_req.op    = mem_in.write ? cache_port_pkg::cache_write
                                       : cache_port_pkg::cache_read;
        cache_req.addr  = addr;
        cache_req.wstrb = strb_base << addr[1:0];   // aligned so nothing drops off
        cache_req.wdata = lane_data;
    end

    // next stage register contents
    always_comb begin
        pass_d = '0;   // idle cycle loads en zero
        if (mem_in.en) begin
            pass_d.en       = 1'b1;
            pass_d.write    = mem_in.write;
            pass_d.sign     = mem_in.sign;
            pass_d.width    = mem_in.width;
            pass_d.rd       = mem_in.rd;
            pass_d.addr_low = addr[1:0];
            // earlier fault wins over our own check
            if (exc_in) begin
                pass_d.exc = mem_in.exc;
            end else if (misalign) begin
                pass_d.exc = mem_pipe_pkg::exc_ale;
            end else begin
                pass_d.exc = mem_pipe_pkg::exc_none;
            end
        end
    end

    // stage register frozen while the cache is busy
    always_ff @(posedge clk) begin
        if (reset) begin
            pass_q <= '0;
        end else if (!stall) begin
            pass_q <= pass_d;   // loads in the same edge the request is taken
        end
    end

    assign pass = pass_q;

endmodule

//--- rtl/data_cache.sv
`timescale 1ns/1ns

module data_cache #(
    parameter int MEM_WORDS   = 1024,
    parameter int MISS_CYCLES = 4,    // at least 1
    parameter int CACHE_LINES = 64
) (
    input  logic                       clk,
    input  logic                       reset,
    input  cache_port_pkg::cache_req_t req,
    output cache_port_pkg::cache_rsp_t rsp
);

    localparam int IDX_W  = $clog2(CACHE_LINES);
    localparam int TAG_W  = 28 - IDX_W;             // above index and 16 byte offset
    localparam int WORD_W = $clog2(MEM_WORDS);
    localparam int CNT_W  = $clog2(MISS_CYCLES + 1);
    localparam logic [31:0] MEM_BYTES = 32'(MEM_WORDS * 4);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,      // tag compare on the latched request
        st_miss_wait    // line already filled, counting out the penalty
    } cache_state_e;

    cache_state_e               state;
    logic [CNT_W-1:0]           miss_cnt;
    cache_port_pkg::cache_req_t req_q;     // request being served

    logic [31:0]            backing [MEM_WORDS];        // stands in for memory
    logic [31:0]            line_data [CACHE_LINES][4];
    logic [TAG_W-1:0]       line_tag [CACHE_LINES];
    logic [CACHE_LINES-1:0] line_valid;

    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic [1:0]        word_off;
    logic [WORD_W-1:0] word_addr;
    logic [WORD_W-1:0] line_base;   // first backing word of the line
    logic              out_range;
    logic              hit;
    logic              rsp_fire;    // answering this cycle
    logic              accept;
    logic              fill;
    logic              store;

    // byte merge by strobe
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // address split
    assign idx       = req_q.addr[4 +: IDX_W];
    assign tag       = req_q.addr[31 -: TAG_W];
    assign word_off  = req_q.addr[3:2];
    assign word_addr = req_q.addr[WORD_W+1:2];
    assign line_base = {req_q.addr[WORD_W+1:4], 2'b00};
    assign out_range = (req_q.addr >= MEM_BYTES);
    assign hit       = line_valid[idx] && (line_tag[idx] == tag);

    assign rsp_fire = ((state == st_lookup) && (out_range || hit)) ||
                      ((state == st_miss_wait) && (miss_cnt == '0));
    // next request may come in the cycle we answer
    assign accept   = req.valid && ((state == st_idle) || rsp_fire);
    assign fill     = (state == st_lookup) && !out_range && !hit;
    assign store    = rsp_fire && !out_range && (req_q.op == cache_port_pkg::cache_write);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            miss_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) state <= st_lookup;
                end
                st_lookup: begin
                    if (fill) begin
                        state    <= st_miss_wait;
                        miss_cnt <= CNT_W'(MISS_CYCLES - 1);   // lookup cycle not counted
                    end else begin
                        state <= accept ? st_lookup : st_idle;
                    end
                end
                st_miss_wait: begin
                    if (miss_cnt != '0) begin
                        miss_cnt <= miss_cnt - 1'b1;
                    end else begin
                        state <= accept ? st_lookup : st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) req_q <= req;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= '0;   // all lines invalid
        end else if (fill) begin
            line_valid[idx] <= 1'b1;
        end
    end

    // whole line copied on a miss, stores land once it is present
    always_ff @(posedge clk) begin
        if (fill) begin
            line_tag[idx] <= tag;
            for (int w = 0; w < 4; w++) begin
                line_data[idx][w] <= backing[line_base + WORD_W'(w)];
            end
        end else if (store) begin
            line_data[idx][word_off] <= merge_bytes(line_data[idx][word_off],
                                                    req_q.wdata, req_q.wstrb);
        end
    end

    // write through
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                backing[i] <= '0;
            end
        end else if (store) begin
            backing[word_addr] <= merge_bytes(backing[word_addr], req_q.wdata, req_q.wstrb);
        end
    end

    // response only from registered state, so no path back to req
    always_comb begin
        rsp.data_valid = rsp_fire;
        rsp.rdata      = '0;
        rsp.exc        = mem_pipe_pkg::exc_none;
        rsp.badv       = '0;
        if (rsp_fire) begin
            if (out_range) begin
                rsp.exc  = mem_pipe_pkg::exc_adem;   // arrays skipped
                rsp.badv = req_q.addr;
            end else begin
                rsp.rdata = line_data[idx][word_off];
            end
        end
    end

endmodule

//--- rtl/mem_response.sv
`timescale 1ns/1ns

module mem_response (
    input  mem_pipe_pkg::mem_pass_t    pass,     // stage register
    input  cache_port_pkg::cache_rsp_t rsp,
    output logic                       stall,    // to issue half and pipeline
    output mem_pipe_pkg::mem_out_t     mem_out
);

    logic                   own_exc;     // access faulted before the cache
    logic                   cache_done;
    mem_pipe_pkg::mem_exc_e cache_exc;
    mem_pipe_pkg::mem_exc_e exc_merged;
    logic [31:0]            shifted;     // addressed lane moved to bit 0
    logic [31:0]            load_val;

    assign own_exc    = (pass.exc != mem_pipe_pkg::exc_none);
    assign cache_done = rsp.data_valid || (rsp.exc != mem_pipe_pkg::exc_none);
    assign cache_exc  = rsp.data_valid ? rsp.exc : mem_pipe_pkg::exc_none;

    // waiting on the cache for an access that went out
    assign stall = pass.en && !own_exc && !cache_done;

    // stage fault first, then the cache one
    always_comb begin
        if (!pass.en) begin
            exc_merged = mem_pipe_pkg::exc_none;
        end else if (own_exc) begin
            exc_merged = pass.exc;
        end else begin
            exc_merged = cache_exc;
        end
    end

    // half offsets are 0 or 2 so one shift covers both sizes
    assign shifted = rsp.rdata >> {pass.addr_low, 3'b000};

    always_comb begin
        case (pass.width)
            mem_pipe_pkg::width_byte:
                load_val = {{24{pass.sign & shifted[7]}}, shifted[7:0]};
            mem_pipe_pkg::width_half:
                load_val = {{16{pass.sign & shifted[15]}}, shifted[15:0]};
            default:
                load_val = rsp.rdata;   // word
        endcase
    end

    always_comb begin
        mem_out.en   = pass.en;
        mem_out.rd   = pass.en ? pass.rd : 5'd0;
        mem_out.exc  = exc_merged;
        mem_out.data = '0;   // stores and faults carry no data
        mem_out.badv = '0;
        if (pass.en && !pass.write && rsp.data_valid &&
            (exc_merged == mem_pipe_pkg::exc_none)) begin
            mem_out.data = load_val;
        end
        // badv only for cache side faults
        if (pass.en && !own_exc && (cache_exc != mem_pipe_pkg::exc_none)) begin
            mem_out.badv = rsp.badv;
        end
    end

endmodule

//--- rtl/mem_stage_top.sv
`timescale 1ns/1ns

module mem_stage_top #(
    parameter int MEM_WORDS   = 1024,   // backing words
    parameter int MISS_CYCLES = 4,      // extra cycles on a miss
    parameter int CACHE_LINES = 64      // 16 byte lines
) (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_pipe_pkg::mem_in_t  mem_in,
    output mem_pipe_pkg::mem_out_t mem_out,
    output logic                   stall     // global hold
);

    cache_port_pkg::cache_req_t cache_req;
    cache_port_pkg::cache_rsp_t cache_rsp;
    mem_pipe_pkg::mem_pass_t    pass;       // in-flight access

    // address, lanes and stage register
    mem_issue u_issue (
        .clk       (clk),
        .reset     (reset),
        .mem_in    (mem_in),
        .stall     (stall),
        .cache_req (cache_req),
        .pass      (pass)
    );

    data_cache #(
        .MEM_WORDS   (MEM_WORDS),
        .MISS_CYCLES (MISS_CYCLES),
        .CACHE_LINES (CACHE_LINES)
    ) u_cache (
        .clk   (clk),
        .reset (reset),
        .req   (cache_req),
        .rsp   (cache_rsp)
    );

    // stall, exception merge and load extension
    mem_response u_resp (
        .pass    (pass),
        .rsp     (cache_rsp),
        .stall   (stall),
        .mem_out (mem_out)
    );

endmodule

//--- bench/mem_stage_vectors.svh
// columns: write width sign rd base imm data exc_in latency
// data only matters on stores, address is base plus imm
// every width stored then read back, first store brings line 0x100 in
add_vec(1'b1, w_word, 1'b0, 5'd1,  32'h110,   32'hfffffff0, 32'h8899aabb, e_none, lat_miss);
add_vec(1'b0, w_word, 1'b0, 5'd2,  32'h100,   32'h0,        32'h0,        e_none, lat_hit);
add_vec(1'b1, w_half, 1'b0, 5'd3,  32'h100,   32'h4,        32'h1234f00d, e_none, lat_hit);
add_vec(1'b1, w_half, 1'b0, 5'd4,  32'h104,   32'h2,        32'h00007e5a, e_none, lat_hit);
add_vec(1'b1, w_byte, 1'b0, 5'd5,  32'h108,   32'h3,        32'h00000085, e_none, lat_hit);
add_vec(1'b1, w_byte, 1'b0, 5'd6,  32'h10c,   32'hfffffffd, 32'hffffff3c, e_none, lat_hit);
add_vec(1'b0, w_half, 1'b1, 5'd7,  32'h104,   32'h0,        32'h0,        e_none, lat_hit);
add_vec(1'b0, w_half, 1'b0, 5'd8,  32'h100,   32'h4,        32'h0,        e_none, lat_hit);
add_vec(1'b0, w_half, 1'b1, 5'd9,  32'h106,   32'h0,        32'h0,        e_none, lat_hit);
add_vec(1'b0, w_byte, 1'b1, 5'd10, 32'h10b,   32'h0,        32'h0,        e_none, lat_hit);
add_vec(1'b0, w_byte, 1'b0, 5'd11, 32'h10b,   32'h0,        32'h0,        e_none, lat_hit);
add_vec(1'b0, w_byte, 1'b1, 5'd12, 32'h109,   32'h0,        32'h0,        e_none, lat_hit);
add_vec(1'b0, w_word, 1'b0, 5'd13, 32'h108,   32'h0,        32'h0,        e_none, lat_hit);
// fresh line misses, next touch hits
add_vec(1'b0, w_word, 1'b1, 5'd14, 32'h200,   32'h0,        32'h0,        e_none, lat_miss);
add_vec(1'b0, w_byte, 1'b1, 5'd15, 32'h20c,   32'h0,        32'h0,        e_none, lat_hit);
// misaligned, memory untouched
add_vec(1'b1, w_half, 1'b0, 5'd16, 32'h101,   32'h0,        32'h0000dead, e_none, lat_exc);
add_vec(1'b1, w_word, 1'b0, 5'd17, 32'h100,   32'h2,        32'hdeadbeef, e_none, lat_exc);
add_vec(1'b0, w_word, 1'b0, 5'd18, 32'h100,   32'h0,        32'h0,        e_none, lat_hit);
add_vec(1'b0, w_half, 1'b1, 5'd19, 32'h107,   32'h0,        32'h0,        e_none, lat_exc);
// past the end of the backing memory
add_vec(1'b0, w_word, 1'b0, 5'd20, 32'h1000,  32'h0,        32'h0,        e_none, lat_exc);
add_vec(1'b1, w_byte, 1'b0, 5'd21, 32'hfff0,  32'h24,       32'h0000005a, e_none, lat_exc);
// upstream fault skips the cache so line 0x300 stays out
add_vec(1'b0, w_word, 1'b0, 5'd22, 32'h300,   32'h0,        32'h0,        e_adem, lat_exc);
add_vec(1'b1, w_word, 1'b0, 5'd23, 32'h104,   32'h0,        32'hcafef00d, e_ale,  lat_exc);
add_vec(1'b0, w_word, 1'b0, 5'd24, 32'h300,   32'h0,        32'h0,        e_none, lat_miss);
add_vec(1'b0, w_word, 1'b0, 5'd25, 32'h104,   32'h0,        32'h0,        e_none, lat_hit);
// en low with busy fields, outputs stay zero
add_vec(1'b1, w_word, 1'b1, 5'd26, 32'h100,   32'h4,        32'hffffffff, e_none, lat_idle);
add_vec(1'b0, w_half, 1'b1, 5'd27, 32'h1000,  32'h1,        32'h0,        e_ale,  lat_idle);

//--- bench/mem_stage_tb.sv
`timescale 1ns/1ns

module mem_stage_tb;

    localparam int MEM_WORDS   = 1024;
    localparam int MISS_CYCLES = 4;
    localparam int CACHE_LINES = 64;
    localparam int MEM_BYTES   = MEM_WORDS * 4;
    localparam int BYTE_W      = $clog2(MEM_BYTES);
    localparam int IDX_W       = $clog2(CACHE_LINES);
    localparam int WAIT_LIMIT  = 20;   // cycles a row may keep stall high

    // short names for the table rows
    localparam mem_pipe_pkg::mem_width_e w_byte = mem_pipe_pkg::width_byte;
    localparam mem_pipe_pkg::mem_width_e w_half = mem_pipe_pkg::width_half;
    localparam mem_pipe_pkg::mem_width_e w_word = mem_pipe_pkg::width_word;
    localparam mem_pipe_pkg::mem_exc_e   e_none = mem_pipe_pkg::exc_none;
    localparam mem_pipe_pkg::mem_exc_e   e_ale  = mem_pipe_pkg::exc_ale;
    localparam mem_pipe_pkg::mem_exc_e   e_adem = mem_pipe_pkg::exc_adem;

    typedef enum logic [2:0] {
        lat_hit,
        lat_miss,
        lat_exc,     // fault, stall never rises
        lat_idle,    // en low
        lat_model    // hit or miss decided by the line model
    } lat_e;

    typedef struct packed {
        logic                     write;
        mem_pipe_pkg::mem_width_e width;
        logic                     sign;
        logic [4:0]               rd;
        logic [31:0]              base;
        logic [31:0]              imm;
        logic [31:0]              data;
        mem_pipe_pkg::mem_exc_e   exc_in;
        lat_e                     lat;
    } vec_t;

    logic                   clk;
    logic                   reset;
    mem_pipe_pkg::mem_in_t  mem_in;
    mem_pipe_pkg::mem_out_t mem_out;
    logic                   stall;

    vec_t        vecs[$];
    logic [7:0]  model_mem [MEM_BYTES];   // byte image of memory
    logic        line_ok [CACHE_LINES];   // which lines the cache should hold
    logic [31:0] line_tag [CACHE_LINES];
    int          pass_count;
    int          fail_count;
    logic        timed_out;

    mem_stage_top #(
        .MEM_WORDS   (MEM_WORDS),
        .MISS_CYCLES (MISS_CYCLES),
        .CACHE_LINES (CACHE_LINES)
    ) dut (
        .clk     (clk),
        .reset   (reset),
        .mem_in  (mem_in),
        .mem_out (mem_out),
        .stall   (stall)
    );

    always #10 clk = ~clk;   // 20 ns period

    task automatic add_vec(input logic write, input mem_pipe_pkg::mem_width_e width,
                           input logic sign, input logic [4:0] rd, input logic [31:0] base,
                           input logic [31:0] imm, input logic [31:0] data,
                           input mem_pipe_pkg::mem_exc_e exc_in, input lat_e lat);
        vec_t v;
        v = '{write, width, sign, rd, base, imm, data, exc_in, lat};
        vecs.push_back(v);
    endtask

    task automatic load_table();
        `include "mem_stage_vectors.svh"
    endtask

    // store then load of one address, each split into base and imm differently
    task automatic add_random_pairs(input int pairs);
        logic [31:0]              addr;
        logic [31:0]              imm;
        logic [4:0]               rd;
        mem_pipe_pkg::mem_width_e w;
        for (int p = 0; p < pairs; p++) begin
            w    = mem_pipe_pkg::mem_width_e'(2'($urandom % 32'd3));
            addr = 32'h400 + ($urandom % 32'd2048);   // tags 1 and 2, some lines collide
            if (w == w_half) begin
                addr[0] = 1'b0;
            end else if (w == w_word) begin
                addr[1:0] = 2'b00;
            end
            rd  = 5'($urandom);
            imm = $urandom % 32'd64;
            add_vec(1'b1, w, 1'b0, rd, addr - imm, imm, $urandom, e_none, lat_model);
            imm = $urandom % 32'd64;
            add_vec(1'b0, w, 1'($urandom), rd + 5'd1, addr - imm, imm, 32'h0, e_none, lat_model);
        end
    endtask

    function automatic logic [7:0] read_byte(input logic [31:0] addr);
        return model_mem[addr[BYTE_W-1:0]];
    endfunction

    function automatic void write_byte(input logic [31:0] addr, input logic [7:0] val);
        model_mem[addr[BYTE_W-1:0]] = val;
    endfunction

    // direct mapped 16 byte lines, every cached access allocates
    function automatic logic access_line(input logic [31:0] addr);
        logic [IDX_W-1:0] idx;
        logic [31:0]      tag;
        logic             hit;
        idx = addr[4 +: IDX_W];
        tag = addr >> (4 + IDX_W);
        hit = line_ok[idx] && (line_tag[idx] == tag);
        line_ok[idx]  = 1'b1;
        line_tag[idx] = tag;
        return hit;
    endfunction

    // expected output and stall length, memory model updated on stores
    task automatic predict(input vec_t v, output mem_pipe_pkg::mem_out_t want,
                           output int want_stall);
        logic [31:0] addr;
        logic [31:0] word;
        logic        misalign;
        logic        was_hit;
        int          nbytes;
        addr       = v.base + v.imm;
        want       = '0;
        want_stall = 0;
        word       = '0;
        case (v.width)
            w_byte:  nbytes = 1;
            w_half:  nbytes = 2;
            default: nbytes = 4;
        endcase
        misalign = (v.width == w_half) ? addr[0] :
                   (v.width == w_word) ? (addr[1:0] != 2'b00) : 1'b0;
        if (v.lat != lat_idle) begin
            want.en = 1'b1;
            want.rd = v.rd;
            if (v.exc_in != e_none) begin
                want.exc = v.exc_in;   // no cache access at all
            end else if (misalign) begin
                want.exc = e_ale;
            end else if (addr >= 32'(MEM_BYTES)) begin
                want.exc  = e_adem;
                want.badv = addr;
            end else begin
                was_hit = access_line(addr);
                if (v.lat == lat_miss || (v.lat == lat_model && !was_hit)) begin
                    want_stall = MISS_CYCLES;
                end
                if (v.write) begin
                    for (int b = 0; b < nbytes; b++) begin
                        write_byte(addr + 32'(b), v.data[8*b +: 8]);
                    end
                end else begin
                    for (int b = 0; b < nbytes; b++) begin
                        word[8*b +: 8] = read_byte(addr + 32'(b));
                    end
                    case (v.width)
                        w_byte:  want.data = {{24{v.sign & word[7]}}, word[7:0]};
                        w_half:  want.data = {{16{v.sign & word[15]}}, word[15:0]};
                        default: want.data = word;
                    endcase
                end
            end
        end
    endtask

    task automatic report_mismatch(input int row, input string name,
                                   input logic [31:0] want_v, input logic [31:0] got_v);
        $display("[FAIL] %0t row %0d %s expected %h got %h", $time, row, name, want_v, got_v);
    endtask

    initial begin
        mem_pipe_pkg::mem_out_t want;
        vec_t v;
        int   want_stall;
        int   stall_cycles;
        int   row_errs;
        void'($urandom(32'h44c34709));
        clk        = 1'b0;
        reset      = 1'b1;
        mem_in     = '0;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        model_mem  = '{default: 8'h00};   // backing memory starts at zero
        line_ok    = '{default: 1'b0};
        line_tag   = '{default: 32'h0};
        load_table();
        add_random_pairs(8);
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < vecs.size() && !timed_out; i++) begin
            v = vecs[i];
            predict(v, want, want_stall);
            mem_in.en    = (v.lat != lat_idle);
            mem_in.write = v.write;
            mem_in.sign  = v.sign;
            mem_in.width = v.width;
            mem_in.rd    = v.rd;
            mem_in.base  = v.base;
            mem_in.imm   = v.imm;
            mem_in.data  = v.data;
            mem_in.exc   = v.exc_in;
            @(posedge clk);   // accepted here
            @(negedge clk);
            stall_cycles = 0;
            while (stall && stall_cycles < WAIT_LIMIT) begin
                stall_cycles++;
                @(negedge clk);
            end
            if (stall) begin
                timed_out = 1'b1;
                $display("timeout: row %0d still stalled after %0d cycles", i, WAIT_LIMIT);
            end else begin
                row_errs = 0;
                if (mem_out.en !== want.en) begin
                    report_mismatch(i, "mem_out.en", 32'(want.en), 32'(mem_out.en));
                    row_errs++;
                end
                if (mem_out.rd !== want.rd) begin
                    report_mismatch(i, "mem_out.rd", 32'(want.rd), 32'(mem_out.rd));
                    row_errs++;
                end
                if (mem_out.data !== want.data) begin
                    report_mismatch(i, "mem_out.data", want.data, mem_out.data);
                    row_errs++;
                end
                if (mem_out.exc !== want.exc) begin
                    report_mismatch(i, "mem_out.exc", 32'(want.exc), 32'(mem_out.exc));
                    row_errs++;
                end
                if (mem_out.badv !== want.badv) begin
                    report_mismatch(i, "mem_out.badv", want.badv, mem_out.badv);
                    row_errs++;
                end
                if (stall_cycles != want_stall) begin
                    report_mismatch(i, "stall cycles", 32'(want_stall), 32'(stall_cycles));
                    row_errs++;
                end
                if (row_errs == 0) begin
                    pass_count++;
                    $display("row %0d ok, stall %0d cycles", i, stall_cycles);
                end else begin
                    fail_count++;
                    $display("row %0d wrong in %0d checks", i, row_errs);
                end
            end
        end
        $display("rows passed %0d failed %0d of %0d", pass_count, fail_count, vecs.size());
        if (timed_out || fail_count != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

//--- build.f
rtl/mem_pipe_pkg.sv
rtl/cache_port_pkg.sv
rtl/mem_issue.sv
rtl/data_cache.sv
rtl/mem_response.sv
rtl/mem_stage_top.sv
+incdir+bench
bench/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mem_stage_sim
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    -f build.f --top-module mem_stage_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
